//--- logic/rv_pkg.sv
package rv_pkg;

    // datapath and address width
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // unified memory geometry, word index sits on address bits 9:2
    localparam int MEM_WORDS = 256;
    localparam int MEM_IDX_W = $clog2(MEM_WORDS);
    localparam MEM_INIT_FILE = "program.hex";

    // major opcodes of the supported subset
    localparam logic [6:0] OPC_OP    = 7'b0110011;
    localparam logic [6:0] OPC_OPIMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD  = 7'b0000011;
    localparam logic [6:0] OPC_STORE = 7'b0100011;

    // funct3 codes shared by decode and the alu
    localparam logic [2:0] F3_ADD  = 3'b000;
    localparam logic [2:0] F3_SLT  = 3'b010;
    localparam logic [2:0] F3_XOR  = 3'b100;
    localparam logic [2:0] F3_OR   = 3'b110;
    localparam logic [2:0] F3_AND  = 3'b111;
    localparam logic [2:0] F3_WORD = 3'b010;

    // funct7 values, bit 30 set picks sub
    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0]        imm_hi;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [4:0]        imm_lo;
        logic [6:0]        opcode;
    } s_fmt_t;

    // one fetched word, three decode views
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } instr_u;

    // ALU_ADD is the plain address add of loads and stores
    typedef enum logic [1:0] {
        ALU_ADD = 2'b00,
        ALU_REG = 2'b01,
        ALU_IMM = 2'b10
    } alu_op_e;

    typedef enum logic {
        WB_ALU = 1'b0,
        WB_MEM = 1'b1
    } wr_mux_e;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        logic [REG_AW-1:0] rs1_addr;
        logic [REG_AW-1:0] rs2_addr;
        logic [REG_AW-1:0] rd_addr;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        logic [2:0]        funct3;
        logic              inst_alu30;
        alu_op_e           alu_op;
        logic              dmem_en;
        logic              dmem_we;
        wr_mux_e           wr_mux;
        logic              wb_en;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic            we;
        logic [XLEN-1:0] addr;
        logic [XLEN-1:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] rdata;
    } mem_rsp_t;

    typedef struct packed {
        logic              valid;
        logic              is_store;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   data;
        logic [XLEN-1:0]   addr;
    } retire_t;

endpackage

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic [REG_AW-1:0] rs1_addr_i,
    output logic [XLEN-1:0]   rs1_data_o,
    input  logic [REG_AW-1:0] rs2_addr_i,
    output logic [XLEN-1:0]   rs2_data_o,
    input  logic              we_i,
    input  logic [REG_AW-1:0] waddr_i,
    input  logic [XLEN-1:0]   wdata_i
);

    logic [XLEN-1:0] regs [2**REG_AW];
    logic            wr_live;

    // writes aimed at x0 are dropped
    assign wr_live = we_i && (waddr_i != '0);

    always_ff @(posedge clk) begin
        // x0 cleared in reset, never written afterwards
        if (!rst_n_i) begin
            regs[0] <= '0;
        end
        if (wr_live) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-through covers a producer two instructions ahead
    assign rs1_data_o = (wr_live && waddr_i == rs1_addr_i) ? wdata_i : regs[rs1_addr_i];
    assign rs2_data_o = (wr_live && waddr_i == rs2_addr_i) ? wdata_i : regs[rs2_addr_i];

    // x0 never picks up a writeback value
    assert property (@(posedge clk) disable iff (!rst_n_i) regs[0] == '0)
        else $error("x0 entry of the register file is nonzero");

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  logic            fetch_grant_i,
    input  mem_rsp_t        fetch_rsp_i,
    output mem_req_t        fetch_req_o,
    output instr_u          instr_o,
    output logic [XLEN-1:0] instr_pc_o,
    output logic            instr_valid_o
);

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pend_pc_q;
    logic            req_en_q;

    // read request at pc every cycle once out of reset
    assign fetch_req_o.valid = req_en_q;
    assign fetch_req_o.we    = 1'b0;
    assign fetch_req_o.addr  = pc_q;
    assign fetch_req_o.wdata = '0;

    // pc moves only when the arbiter lets the fetch through
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            req_en_q <= 1'b0;
            pc_q     <= '0;
        end else begin
            req_en_q <= 1'b1;
            if (fetch_grant_i) begin
                pc_q <= pc_q + XLEN'(4);
            end
        end
    end

    // address of the word now in flight
    always_ff @(posedge clk) begin
        if (fetch_grant_i) begin
            pend_pc_q <= pc_q;
        end
    end

    // returned word paired with its own pc
    assign instr_o       = fetch_rsp_i.rdata;
    assign instr_pc_o    = pend_pc_q;
    assign instr_valid_o = fetch_rsp_i.valid;

endmodule

//--- logic/decode_unit.sv
`timescale 1ns/1ps

module decode_unit import rv_pkg::*; (
    input  instr_u            instr_i,
    input  logic [XLEN-1:0]   instr_pc_i,
    input  logic              instr_valid_i,
    input  logic [XLEN-1:0]   rs1_data_i,
    input  logic [XLEN-1:0]   rs2_data_i,
    output logic [REG_AW-1:0] rs1_addr_o,
    output logic [REG_AW-1:0] rs2_addr_o,
    output id_ex_t            dec_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       legal;

    // opcode, funct3 and source fields sit at the same bits in every format
    assign opcode     = instr_i.r_fmt.opcode;
    assign funct3     = instr_i.r_fmt.funct3;
    assign funct7     = instr_i.r_fmt.funct7;
    assign rs1_addr_o = instr_i.r_fmt.rs1;
    assign rs2_addr_o = instr_i.r_fmt.rs2;

    always_comb begin
        dec_o            = '0;
        dec_o.pc         = instr_pc_i;
        dec_o.rs1_addr   = instr_i.r_fmt.rs1;
        dec_o.rs2_addr   = instr_i.r_fmt.rs2;
        dec_o.rd_addr    = instr_i.r_fmt.rd;
        dec_o.rs1_data   = rs1_data_i;
        dec_o.rs2_data   = rs2_data_i;
        dec_o.funct3     = funct3;
        dec_o.inst_alu30 = funct7[5];
        dec_o.alu_op     = ALU_ADD;
        dec_o.wr_mux     = WB_ALU;
        // i-type immediate unless a store says otherwise
        dec_o.imm        = {{(XLEN-12){instr_i.i_fmt.imm[11]}}, instr_i.i_fmt.imm};
        legal            = 1'b0;
        case (opcode)
            OPC_OP: begin
                dec_o.alu_op = ALU_REG;
                dec_o.wb_en  = 1'b1;
                // only add may take the alternate funct7
                if (funct7 == F7_ALT) begin
                    legal = (funct3 == F3_ADD);
                end else begin
                    legal = (funct7 == F7_BASE) &&
                            (funct3 inside {F3_ADD, F3_SLT, F3_XOR, F3_OR, F3_AND});
                end
            end
            OPC_OPIMM: begin
                dec_o.alu_op = ALU_IMM;
                dec_o.wb_en  = 1'b1;
                legal        = funct3 inside {F3_ADD, F3_XOR, F3_OR, F3_AND};
            end
            OPC_LOAD: begin
                dec_o.dmem_en = 1'b1;
                dec_o.wr_mux  = WB_MEM;
                dec_o.wb_en   = 1'b1;
                legal         = (funct3 == F3_WORD);
            end
            OPC_STORE: begin
                // split immediate, rd field belongs to it
                dec_o.imm     = {{(XLEN-12){instr_i.s_fmt.imm_hi[6]}},
                                 instr_i.s_fmt.imm_hi, instr_i.s_fmt.imm_lo};
                dec_o.rd_addr = '0;
                dec_o.dmem_en = 1'b1;
                dec_o.dmem_we = 1'b1;
                legal         = (funct3 == F3_WORD);
            end
            default: begin
                legal = 1'b0;
            end
        endcase
        // bubble for anything outside the subset
        dec_o.valid = instr_valid_i && legal;
        if (!legal || dec_o.rd_addr == '0) begin
            dec_o.wb_en = 1'b0;
        end
    end

endmodule

//--- logic/id_ex.sv
`timescale 1ns/1ps

module id_ex import rv_pkg::*; (
    input  logic   clk,
    input  logic   rst_n_i,
    input  id_ex_t dec_i,
    output id_ex_t ex_o
);

    id_ex_t ex_q;

    // whole bundle moves every cycle, no stall
    always_ff @(posedge clk) begin
        ex_q <= dec_i;
        // only the valid bit is cleared
        if (!rst_n_i) begin
            ex_q.valid <= 1'b0;
        end
    end

    assign ex_o = ex_q;

    // first fetch is still in flight, execute sees a bubble after release
    assert property (@(posedge clk) $rose(rst_n_i) |=> !ex_o.valid)
        else $error("id_ex valid set in the cycle after reset");

endmodule

//--- logic/execute_unit.sv
`timescale 1ns/1ps

module execute_unit import rv_pkg::*; (
    input  logic              clk,
    input  logic              rst_n_i,
    input  id_ex_t            ex_i,
    input  mem_rsp_t          data_rsp_i,
    output mem_req_t          data_req_o,
    output logic              rf_we_o,
    output logic [REG_AW-1:0] rf_waddr_o,
    output logic [XLEN-1:0]   rf_wdata_o,
    output retire_t           retire_o
);

    // writeback stage contents
    typedef struct packed {
        logic              valid;
        logic              wb_en;
        wr_mux_e           wr_mux;
        logic              is_store;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   result;
        logic [XLEN-1:0]   addr;
    } wb_t;

    wb_t             wb_q;
    logic [XLEN-1:0] wb_value;
    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_res;
    logic            fwd_en;
    logic            is_sub;
    logic            is_store;

    // load data arrives from memory in the writeback cycle
    assign wb_value = (wb_q.wr_mux == WB_MEM) ? data_rsp_i.rdata : wb_q.result;
    assign fwd_en   = wb_q.valid && wb_q.wb_en && (wb_q.rd != '0);

    // bypass from the instruction one ahead
    assign src1 = (fwd_en && wb_q.rd == ex_i.rs1_addr) ? wb_value : ex_i.rs1_data;
    assign src2 = (fwd_en && wb_q.rd == ex_i.rs2_addr) ? wb_value : ex_i.rs2_data;

    assign op_b     = (ex_i.alu_op == ALU_REG) ? src2 : ex_i.imm;
    assign is_sub   = (ex_i.alu_op == ALU_REG) && ex_i.inst_alu30;
    assign is_store = ex_i.dmem_en && ex_i.dmem_we;

    always_comb begin
        alu_res = src1 + op_b;
        // funct3 only matters for arithmetic ops
        if (ex_i.alu_op != ALU_ADD) begin
            case (ex_i.funct3)
                F3_ADD:  alu_res = is_sub ? (src1 - op_b) : (src1 + op_b);
                F3_SLT:  alu_res = {{(XLEN-1){1'b0}}, ($signed(src1) < $signed(op_b))};
                F3_XOR:  alu_res = src1 ^ op_b;
                F3_OR:   alu_res = src1 | op_b;
                F3_AND:  alu_res = src1 & op_b;
                default: alu_res = src1 + op_b;
            endcase
        end
    end

    // load or store goes out in this cycle and wins the memory
    assign data_req_o.valid = ex_i.valid && ex_i.dmem_en;
    assign data_req_o.we    = ex_i.dmem_we;
    assign data_req_o.addr  = alu_res;
    assign data_req_o.wdata = src2;

    always_ff @(posedge clk) begin
        wb_q.valid    <= ex_i.valid;
        wb_q.wb_en    <= ex_i.wb_en;
        wb_q.wr_mux   <= ex_i.wr_mux;
        wb_q.is_store <= is_store;
        wb_q.rd       <= ex_i.rd_addr;
        // a store keeps its data word and address for the retire port
        wb_q.result   <= is_store ? src2 : alu_res;
        wb_q.addr     <= is_store ? alu_res : '0;
        if (!rst_n_i) begin
            wb_q.valid <= 1'b0;
        end
    end

    assign rf_we_o    = wb_q.valid && wb_q.wb_en;
    assign rf_waddr_o = wb_q.rd;
    assign rf_wdata_o = wb_value;

    // x0 writes and bubbles retire nothing
    assign retire_o.valid    = wb_q.valid && (wb_q.wb_en || wb_q.is_store);
    assign retire_o.is_store = wb_q.is_store;
    assign retire_o.rd       = wb_q.rd;
    assign retire_o.data     = wb_value;
    assign retire_o.addr     = wb_q.addr;

    // read issued a cycle earlier must come back through the arbiter now
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (wb_q.valid && wb_q.wr_mux == WB_MEM) |-> data_rsp_i.valid)
        else $error("load in writeback without a data response");

endmodule

//--- logic/mem_arbiter.sv
`timescale 1ns/1ps

module mem_arbiter import rv_pkg::*; (
    input  logic            clk,
    input  logic            rst_n_i,
    input  mem_req_t        fetch_req_i,
    input  mem_req_t        data_req_i,
    output logic            fetch_grant_o,
    output mem_rsp_t        fetch_rsp_o,
    output mem_rsp_t        data_rsp_o,
    output mem_req_t        mem_req_o,
    input  logic [XLEN-1:0] mem_rdata_i
);

    logic data_own_q;
    logic fetch_own_q;

    // data side first, fetch gets the port otherwise
    assign fetch_grant_o = fetch_req_i.valid && !data_req_i.valid;
    assign mem_req_o     = data_req_i.valid ? data_req_i : fetch_req_i;

    // owner of the access now in the memory
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            data_own_q  <= 1'b0;
            fetch_own_q <= 1'b0;
        end else begin
            data_own_q  <= data_req_i.valid;
            fetch_own_q <= fetch_grant_o;
        end
    end

    // read data steered to whoever won last cycle
    assign fetch_rsp_o.valid = fetch_own_q;
    assign fetch_rsp_o.rdata = mem_rdata_i;
    assign data_rsp_o.valid  = data_own_q;
    assign data_rsp_o.rdata  = mem_rdata_i;

    assert property (@(posedge clk) disable iff (!rst_n_i)
        !(fetch_rsp_o.valid && data_rsp_o.valid))
        else $error("fetch and data responses valid together");

endmodule

//--- logic/unified_mem.sv
`timescale 1ns/1ps

module unified_mem import rv_pkg::*; (
    input  logic            clk,
    input  mem_req_t        mem_req_i,
    output logic [XLEN-1:0] mem_rdata_o
);

    logic [XLEN-1:0]      mem [MEM_WORDS];
    logic [MEM_IDX_W-1:0] idx;

    // program at word 0, data further up
    initial begin
        $readmemh(MEM_INIT_FILE, mem);
    end

    // word index, byte offset dropped
    assign idx = mem_req_i.addr[MEM_IDX_W+1:2];

    // store lands in the granted cycle, read data one cycle later
    always_ff @(posedge clk) begin
        if (mem_req_i.valid) begin
            if (mem_req_i.we) begin
                mem[idx] <= mem_req_i.wdata;
            end
            mem_rdata_o <= mem[idx];
        end
    end

endmodule

//--- logic/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top import rv_pkg::*; (
    input  logic    clk,
    input  logic    rst_n_i,
    output retire_t retire_o
);

    // memory path
    mem_req_t          fetch_req;
    mem_req_t          data_req;
    mem_req_t          mem_req;
    mem_rsp_t          fetch_rsp;
    mem_rsp_t          data_rsp;
    logic              fetch_grant;
    logic [XLEN-1:0]   mem_rdata;

    // pipeline path
    instr_u            instr;
    logic [XLEN-1:0]   instr_pc;
    logic              instr_valid;
    id_ex_t            dec;
    id_ex_t            ex;

    // register file ports
    logic [REG_AW-1:0] rs1_addr;
    logic [REG_AW-1:0] rs2_addr;
    logic [XLEN-1:0]   rs1_data;
    logic [XLEN-1:0]   rs2_data;
    logic              rf_we;
    logic [REG_AW-1:0] rf_waddr;
    logic [XLEN-1:0]   rf_wdata;

    fetch_unit u_fetch (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_grant_i (fetch_grant),
        .fetch_rsp_i   (fetch_rsp),
        .fetch_req_o   (fetch_req),
        .instr_o       (instr),
        .instr_pc_o    (instr_pc),
        .instr_valid_o (instr_valid)
    );

    decode_unit u_decode (
        .instr_i       (instr),
        .instr_pc_i    (instr_pc),
        .instr_valid_i (instr_valid),
        .rs1_data_i    (rs1_data),
        .rs2_data_i    (rs2_data),
        .rs1_addr_o    (rs1_addr),
        .rs2_addr_o    (rs2_addr),
        .dec_o         (dec)
    );

    reg_file u_regs (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rs1_addr_i (rs1_addr),
        .rs1_data_o (rs1_data),
        .rs2_addr_i (rs2_addr),
        .rs2_data_o (rs2_data),
        .we_i       (rf_we),
        .waddr_i    (rf_waddr),
        .wdata_i    (rf_wdata)
    );

    id_ex u_id_ex (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .dec_i   (dec),
        .ex_o    (ex)
    );

    execute_unit u_execute (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ex_i       (ex),
        .data_rsp_i (data_rsp),
        .data_req_o (data_req),
        .rf_we_o    (rf_we),
        .rf_waddr_o (rf_waddr),
        .rf_wdata_o (rf_wdata),
        .retire_o   (retire_o)
    );

    mem_arbiter u_arbiter (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .fetch_req_i   (fetch_req),
        .data_req_i    (data_req),
        .fetch_grant_o (fetch_grant),
        .fetch_rsp_o   (fetch_rsp),
        .data_rsp_o    (data_rsp),
        .mem_req_o     (mem_req),
        .mem_rdata_i   (mem_rdata)
    );

    unified_mem u_mem (
        .clk         (clk),
        .mem_req_i   (mem_req),
        .mem_rdata_o (mem_rdata)
    );

endmodule

//--- verification/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core import rv_pkg::*; ();

    logic    clk;
    logic    rst_n_i;
    retire_t retire_o;

    // program-order reference model
    logic [XLEN-1:0] model_mem  [MEM_WORDS];
    logic [XLEN-1:0] model_regs [2**REG_AW];
    int              model_pc;
    retire_t         exp_ret;
    logic            exp_live;

    // bookkeeping
    int   retire_seen;
    int   exp_total;
    int   mismatch_errors;
    int   other_errors;
    int   wait_cycles;

    rv_core_top uut (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .retire_o (retire_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [XLEN-1:0] sext12(input logic [11:0] v);
        return {{(XLEN-12){v[11]}}, v};
    endfunction

    // subset membership, unknown words fall into default
    function automatic logic is_legal(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        f3 = w[14:12];
        f7 = w[31:25];
        case (w[6:0])
            OPC_OP: begin
                return (f7 == 7'h00 && f3 inside {3'd0, 3'd2, 3'd4, 3'd6, 3'd7}) ||
                       (f7 == 7'h20 && f3 == 3'd0);
            end
            OPC_OPIMM: return f3 inside {3'd0, 3'd4, 3'd6, 3'd7};
            OPC_LOAD:  return f3 == 3'd2;
            OPC_STORE: return f3 == 3'd2;
            default:   return 1'b0;
        endcase
    endfunction

    // stores always retire, writes only with a nonzero rd
    function automatic logic retires(input logic [31:0] w);
        return is_legal(w) && (w[6:0] == OPC_STORE || w[11:7] != 5'd0);
    endfunction

    // arithmetic of the subset, bit 30 picks sub for register ops
    function automatic logic [XLEN-1:0] alu_result(input logic [31:0] w,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        case (w[14:12])
            3'd0:    return (w[6:0] == OPC_OP && w[30]) ? a - b : a + b;
            3'd2:    return ($signed(a) < $signed(b)) ? XLEN'(1) : XLEN'(0);
            3'd4:    return a ^ b;
            3'd6:    return a | b;
            default: return a & b;
        endcase
    endfunction

    // walk to the next retiring word and predict its retire port
    task automatic find_next_retire();
        logic [31:0]     w;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] ea;
        exp_live = 1'b0;
        exp_ret  = '0;
        while (!exp_live && model_pc < MEM_WORDS / 2) begin
            w = model_mem[model_pc];
            if (retires(w)) begin
                a = model_regs[w[19:15]];
                exp_ret.valid = 1'b1;
                if (w[6:0] == OPC_STORE) begin
                    // split immediate, rs2 is the stored word
                    exp_ret.is_store = 1'b1;
                    exp_ret.addr     = a + sext12({w[31:25], w[11:7]});
                    exp_ret.data     = model_regs[w[24:20]];
                end else if (w[6:0] == OPC_LOAD) begin
                    ea           = a + sext12(w[31:20]);
                    exp_ret.rd   = w[11:7];
                    exp_ret.data = model_mem[(ea / 4) % MEM_WORDS];
                end else begin
                    b            = (w[6:0] == OPC_OP) ? model_regs[w[24:20]] : sext12(w[31:20]);
                    exp_ret.rd   = w[11:7];
                    exp_ret.data = alu_result(w, a, b);
                end
                exp_live = 1'b1;
            end else begin
                // bubble or x0 write, no architectural effect
                model_pc = model_pc + 1;
            end
        end
    endtask

    // apply the predicted effect, then look ahead
    task automatic commit_retire();
        if (exp_ret.is_store) begin
            model_mem[(exp_ret.addr / 4) % MEM_WORDS] = exp_ret.data;
        end else begin
            model_regs[exp_ret.rd] = exp_ret.data;
        end
        model_pc = model_pc + 1;
        find_next_retire();
    endtask

    // model steps once per retirement of the core
    always @(posedge clk) begin
        if (rst_n_i && retire_o.valid === 1'b1 && exp_live) begin
            commit_retire();
            retire_seen <= retire_seen + 1;
        end
    end

    // quiet retire port in reset and the cycle after release
    assert property (@(posedge clk) !rst_n_i |=> !retire_o.valid)
        else begin
            other_errors = other_errors + 1;
            $display("%0t: retire valid set during reset or right after it", $time);
        end

    assert property (@(posedge clk) rst_n_i |-> !$isunknown(retire_o.valid))
        else begin
            other_errors = other_errors + 1;
            $display("%0t: retire valid is unknown out of reset", $time);
        end

    // no retirement past the end of the program
    assert property (@(posedge clk) disable iff (!rst_n_i) retire_o.valid |-> exp_live)
        else begin
            other_errors = other_errors + 1;
            $display("%0t: retirement with no instruction left in the program", $time);
        end

    // x0 writes never show up on the port
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (retire_o.valid && !retire_o.is_store) |-> retire_o.rd != '0)
        else begin
            other_errors = other_errors + 1;
            $display("%0t: register retirement names x0", $time);
        end

    // whole retire word against the model, in program order
    assert property (@(posedge clk) disable iff (!rst_n_i)
        (retire_o.valid && exp_live) |-> retire_o == exp_ret)
        else begin
            mismatch_errors = mismatch_errors + 1;
            $display({"MISMATCH %0t: retire got st=%0b rd=%0d data=%h addr=%h,",
                      " exp st=%0b rd=%0d data=%h addr=%h"},
                     $time, $sampled(retire_o.is_store), $sampled(retire_o.rd),
                     $sampled(retire_o.data), $sampled(retire_o.addr),
                     $sampled(exp_ret.is_store), $sampled(exp_ret.rd),
                     $sampled(exp_ret.data), $sampled(exp_ret.addr));
        end

    initial begin
        rst_n_i         = 1'b0;
        retire_seen     = 0;
        mismatch_errors = 0;
        other_errors    = 0;
        model_pc        = 0;
        $readmemh(MEM_INIT_FILE, model_mem);
        for (int r = 0; r < 2**REG_AW; r++) begin
            model_regs[r] = '0;
        end
        // retiring words in the program area
        exp_total = 0;
        for (int i = 0; i < MEM_WORDS / 2; i++) begin
            if (retires(model_mem[i])) begin
                exp_total = exp_total + 1;
            end
        end
        find_next_retire();
        $display("expecting %0d retirements", exp_total);

        repeat (2) @(posedge clk);
        rst_n_i <= 1'b1;

        // bounded well below the pc wrap at the end of memory
        wait_cycles = 0;
        while (retire_seen < exp_total && wait_cycles < MEM_WORDS) begin
            @(posedge clk);
            wait_cycles = wait_cycles + 1;
        end
        if (retire_seen < exp_total) begin
            other_errors = other_errors + 1;
            $display("timeout: only %0d of %0d instructions retired", retire_seen, exp_total);
        end
        // let the checks of the last edge finish
        @(negedge clk);

        $display("errors: %0d mismatches, %0d other failures", mismatch_errors, other_errors);
        if (mismatch_errors == 0 && other_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- sim.f
logic/rv_pkg.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/decode_unit.sv
logic/id_ex.sv
logic/execute_unit.sv
logic/mem_arbiter.sv
logic/unified_mem.sv
logic/rv_core_top.sv
verification/tb_rv_core.sv

//--- program.hex
// one 32-bit word per line in hex, instruction in comment
// program from word 0, data block from word 128 (@80)
00500093 // addi x1, x0, 5
ffd00113 // addi x2, x0, -3
002081b3 // add  x3, x1, x2
40118233 // sub  x4, x3, x1
001122b3 // slt  x5, x2, x1
0020a333 // slt  x6, x1, x2
0020f3b3 // and  x7, x1, x2
0020e433 // or   x8, x1, x2
0020c4b3 // xor  x9, x1, x2
0ff4f513 // andi x10, x9, 0xff
10056593 // ori  x11, x10, 0x100
fff5c613 // xori x12, x11, -1
00708013 // addi x0, x1, 7
001006b3 // add  x13, x0, x1
000000ef // jal  x1, 0 (outside the subset)
20000713 // addi x14, x0, 0x200
00c72223 // sw   x12, 4(x14)
00472783 // lw   x15, 4(x14)
00178833 // add  x16, x15, x1
00072883 // lw   x17, 0(x14)
0108c933 // xor  x18, x17, x16
01272423 // sw   x18, 8(x14)
00872983 // lw   x19, 8(x14)
41198a33 // sub  x20, x19, x17
004a2ab3 // slt  x21, x20, x4
@80
13572468
0badf00d
00000000
